//--- include/servo_consts.svh
`ifndef SERVO_CONSTS_SVH
`define SERVO_CONSTS_SVH

// **********************************************************************
// Timing constants for the servo controller.
// **********************************************************************

// Clocks per timer tick.
`define SERVO_PRESCALE 4

// Timer ticks per servo move.
`define SERVO_MOVE_TICKS 6

// Command queue depth.
`define SERVO_FIFO_DEPTH 4

// PWM frame length and pulse widths, in clocks.
`define SERVO_PWM_PERIOD 100
`define SERVO_PULSE_UP 30
`define SERVO_PULSE_DOWN 12

`endif

//--- hdl/servo_pkg.sv
package servo_pkg;

	// Resting position requested by the host.
	typedef enum logic {
		SERVO_POS_UP   = 1'b0,
		SERVO_POS_DOWN = 1'b1
	} servo_pos_t;

	// Rotation direction while a move is in progress.
	typedef enum logic [1:0] {
		SERVO_DIR_STAY = 2'd0,
		SERVO_DIR_UP   = 2'd1,
		SERVO_DIR_DOWN = 2'd2
	} servo_dir_t;

	// Host command codes.
	typedef enum logic [1:0] {
		OP_NOP  = 2'd0,
		OP_UP   = 2'd1,
		OP_DOWN = 2'd2,
		OP_BAD  = 2'd3
	} servo_op_t;

endpackage : servo_pkg

//--- hdl/servo_cmd_decoder.sv
`timescale 1ns/1ps

module servo_cmd_decoder
	import servo_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       cmd_strobe,
	input  servo_op_t  cmd_code,
	output logic       push,
	output servo_pos_t push_pos,
	output logic       reject
);

	logic       is_move;
	logic       is_bad;
	servo_pos_t move_pos;

	// Classify the incoming code.
	always_comb begin
		is_move  = 1'b0;
		is_bad   = 1'b0;
		move_pos = SERVO_POS_UP;
		case (cmd_code)
			OP_UP: begin
				is_move  = 1'b1;
				move_pos = SERVO_POS_UP;
			end
			OP_DOWN: begin
				is_move  = 1'b1;
				move_pos = SERVO_POS_DOWN;
			end
			OP_BAD: begin
				is_bad = 1'b1;
			end
			default: begin
				// NOP, nothing to do.
				is_move = 1'b0;
			end
		endcase
	end

	// Strobes, one clock behind the host strobe.
	always_ff @(posedge clk) begin
		if (reset) begin
			push   <= 1'b0;
			reject <= 1'b0;
		end else begin
			push   <= cmd_strobe && is_move;
			reject <= cmd_strobe && is_bad;
		end
	end

	// Target position travels alongside push.
	always_ff @(posedge clk) begin
		if (cmd_strobe && is_move) begin
			push_pos <= move_pos;
		end
	end

	a_push_reject_excl: assert property (@(posedge clk) disable iff (reset)
		!(push && reject));

endmodule : servo_cmd_decoder

//--- hdl/servo_cmd_fifo.sv
`timescale 1ns/1ps

module servo_cmd_fifo
	import servo_pkg::*;
#(
	parameter int DEPTH = 4
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       push,
	input  servo_pos_t push_pos,
	input  logic       consumer_rdy,
	input  logic       tick,
	output logic       cmd_valid,
	output servo_pos_t cmd_pos,
	output logic       overflow
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
	localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

	servo_pos_t       mem [DEPTH];
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] count_nxt;
	logic             full;
	logic             pop;
	logic             wr_en;

	assign full = (count == FULL_CNT);
	// Head leaves on the tick where the FSM accepts it.
	assign pop = consumer_rdy && tick && cmd_valid;
	// A pop in the same cycle frees a slot for the push.
	assign wr_en = push && (!full || pop);
	assign cmd_pos = mem[rd_ptr];

	always_comb begin
		count_nxt = count;
		if (wr_en && !pop) begin
			count_nxt = count + 1'b1;
		end else if (pop && !wr_en) begin
			count_nxt = count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_ptr    <= '0;
			wr_ptr    <= '0;
			count     <= '0;
			cmd_valid <= 1'b0;
			overflow  <= 1'b0;
		end else begin
			if (wr_en) begin
				wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
			end
			count     <= count_nxt;
			cmd_valid <= (count_nxt != '0);
			// Sticky until reset.
			if (push && !wr_en) begin
				overflow <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= push_pos;
		end
	end

	a_count_bound: assert property (@(posedge clk) disable iff (reset)
		count <= FULL_CNT);
	a_no_pop_empty: assert property (@(posedge clk) disable iff (reset)
		pop |-> (count != '0));

endmodule : servo_cmd_fifo

//--- hdl/servo_ctrl_fsm.sv
`timescale 1ns/1ps

module servo_ctrl_fsm
	import servo_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       clk_en,
	input  logic       trigger,
	input  logic       timer_done,
	input  logic       timer_rdy,
	input  servo_pos_t servo_pos,
	output logic       timer_trigger,
	output servo_dir_t servo_dir,
	output logic       done,
	output logic       rdy
);

	typedef enum logic [2:0] {
		IDLE_UP,
		IDLE_DOWN,
		TRIGGER_TIMER_UP,
		TRIGGER_TIMER_DOWN,
		WORKING_UP_TO_DOWN,
		WORKING_DOWN_TO_UP,
		DONE_UP,
		DONE_DOWN
	} state_t;

	state_t cur_state;
	state_t nxt_state;

	// **********************************************************************
	// Next state and outputs.
	// **********************************************************************
	always_comb begin
		nxt_state     = cur_state;
		timer_trigger = 1'b0;
		servo_dir     = SERVO_DIR_STAY;
		done          = 1'b0;
		rdy           = 1'b0;
		case (cur_state)
			IDLE_UP: begin
				done = 1'b1;
				rdy  = 1'b1;
				if (trigger) begin
					done = 1'b0;
					// Same position or busy timer goes straight to done.
					nxt_state = DONE_UP;
					if (servo_pos == SERVO_POS_DOWN && timer_rdy) begin
						nxt_state = TRIGGER_TIMER_UP;
					end
				end
			end
			IDLE_DOWN: begin
				done = 1'b1;
				rdy  = 1'b1;
				if (trigger) begin
					done      = 1'b0;
					nxt_state = DONE_DOWN;
					if (servo_pos == SERVO_POS_UP && timer_rdy) begin
						nxt_state = TRIGGER_TIMER_DOWN;
					end
				end
			end
			TRIGGER_TIMER_UP: begin
				timer_trigger = 1'b1;
				// Timer has taken the trigger.
				if (!timer_rdy) begin
					nxt_state = WORKING_UP_TO_DOWN;
				end
			end
			TRIGGER_TIMER_DOWN: begin
				timer_trigger = 1'b1;
				if (!timer_rdy) begin
					nxt_state = WORKING_DOWN_TO_UP;
				end
			end
			WORKING_UP_TO_DOWN: begin
				servo_dir = SERVO_DIR_DOWN;
				if (timer_done) begin
					done      = 1'b1;
					nxt_state = DONE_DOWN;
				end
			end
			WORKING_DOWN_TO_UP: begin
				servo_dir = SERVO_DIR_UP;
				if (timer_done) begin
					done      = 1'b1;
					nxt_state = DONE_UP;
				end
			end
			DONE_UP: begin
				done      = 1'b1;
				nxt_state = IDLE_UP;
			end
			DONE_DOWN: begin
				done      = 1'b1;
				nxt_state = IDLE_DOWN;
			end
			default: begin
				nxt_state = IDLE_UP;
			end
		endcase
	end

	// State only moves on a timer tick.
	always_ff @(posedge clk) begin
		if (reset) begin
			cur_state <= IDLE_UP;
		end else if (clk_en) begin
			cur_state <= nxt_state;
		end
	end

	// Timer must accept the trigger before the next tick.
	a_trigger_taken: assert property (@(posedge clk) disable iff (reset)
		(timer_trigger && clk_en) |-> !timer_rdy);

endmodule : servo_ctrl_fsm

//--- hdl/servo_move_timer.sv
`timescale 1ns/1ps
`include "servo_consts.svh"

module servo_move_timer (
	input  logic clk,
	input  logic reset,
	input  logic timer_trigger,
	output logic tick,
	output logic timer_rdy,
	output logic timer_done
);

	localparam int PRE_W = ($clog2(`SERVO_PRESCALE) > 0) ? $clog2(`SERVO_PRESCALE) : 1;
	localparam int MOV_W = $clog2(`SERVO_MOVE_TICKS + 1);
	localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(`SERVO_PRESCALE - 1);
	localparam logic [MOV_W-1:0] MOV_LOAD = MOV_W'(`SERVO_MOVE_TICKS);

	logic [PRE_W-1:0] pre_cnt;
	logic [MOV_W-1:0] mov_cnt;
	logic             busy;

	// Prescaler, one tick per SERVO_PRESCALE clocks.
	always_ff @(posedge clk) begin
		if (reset) begin
			pre_cnt <= '0;
			tick    <= 1'b0;
		end else if (pre_cnt == PRE_LAST) begin
			pre_cnt <= '0;
			tick    <= 1'b1;
		end else begin
			pre_cnt <= pre_cnt + 1'b1;
			tick    <= 1'b0;
		end
	end

	// Movement counter.
	always_ff @(posedge clk) begin
		if (reset) begin
			mov_cnt    <= '0;
			busy       <= 1'b0;
			timer_done <= 1'b0;
		end else if (timer_trigger && !busy) begin
			mov_cnt    <= MOV_LOAD;
			busy       <= 1'b1;
			timer_done <= 1'b0;
		end else if (busy && tick) begin
			mov_cnt <= mov_cnt - 1'b1;
			// Last tick of the move.
			if (mov_cnt == MOV_W'(1)) begin
				busy       <= 1'b0;
				timer_done <= 1'b1;
			end
		end
	end

	assign timer_rdy = !busy;

endmodule : servo_move_timer

//--- hdl/servo_pwm.sv
`timescale 1ns/1ps
`include "servo_consts.svh"

module servo_pwm
	import servo_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  servo_dir_t servo_dir,
	output logic       pwm_out
);

	localparam int CNT_W = $clog2(`SERVO_PWM_PERIOD);
	localparam logic [CNT_W-1:0] FRAME_LAST = CNT_W'(`SERVO_PWM_PERIOD - 1);
	localparam logic [CNT_W-1:0] WIDTH_UP   = CNT_W'(`SERVO_PULSE_UP);
	localparam logic [CNT_W-1:0] WIDTH_DOWN = CNT_W'(`SERVO_PULSE_DOWN);

	servo_pos_t       cur_pos;
	logic [CNT_W-1:0] frame_cnt;
	logic [CNT_W-1:0] pulse_width;

	// Remember where the last move was heading.
	always_ff @(posedge clk) begin
		if (reset) begin
			cur_pos <= SERVO_POS_UP;
		end else begin
			case (servo_dir)
				SERVO_DIR_UP:   cur_pos <= SERVO_POS_UP;
				SERVO_DIR_DOWN: cur_pos <= SERVO_POS_DOWN;
				default:        cur_pos <= cur_pos;
			endcase
		end
	end

	// **********************************************************************
	// Frame counter and pulse width.
	// **********************************************************************
	always_ff @(posedge clk) begin
		if (reset) begin
			frame_cnt   <= '0;
			pulse_width <= WIDTH_UP;
		end else if (frame_cnt == FRAME_LAST) begin
			frame_cnt <= '0;
			// New width takes effect with the next frame.
			pulse_width <= (cur_pos == SERVO_POS_DOWN) ? WIDTH_DOWN : WIDTH_UP;
		end else begin
			frame_cnt <= frame_cnt + 1'b1;
		end
	end

	// High at the start of each frame.
	assign pwm_out = (frame_cnt < pulse_width);

endmodule : servo_pwm

//--- hdl/servo_top.sv
`timescale 1ns/1ps
`include "servo_consts.svh"

module servo_top
	import servo_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       cmd_strobe,
	input  servo_op_t  cmd_code,
	output logic       pwm_out,
	output servo_dir_t servo_dir,
	output logic       done,
	output logic       rdy,
	output logic       overflow,
	output logic       reject
);

	logic       push;
	servo_pos_t push_pos;
	logic       cmd_valid;
	servo_pos_t cmd_pos;
	logic       tick;
	logic       timer_trigger;
	logic       timer_rdy;
	logic       timer_done;

	servo_cmd_decoder decoder_i (
		.clk        (clk),
		.reset      (reset),
		.cmd_strobe (cmd_strobe),
		.cmd_code   (cmd_code),
		.push       (push),
		.push_pos   (push_pos),
		.reject     (reject)
	);

	servo_cmd_fifo #(
		.DEPTH (`SERVO_FIFO_DEPTH)
	) fifo_i (
		.clk          (clk),
		.reset        (reset),
		.push         (push),
		.push_pos     (push_pos),
		.consumer_rdy (rdy),
		.tick         (tick),
		.cmd_valid    (cmd_valid),
		.cmd_pos      (cmd_pos),
		.overflow     (overflow)
	);

	// Queue head feeds the FSM trigger.
	servo_ctrl_fsm fsm_i (
		.clk           (clk),
		.reset         (reset),
		.clk_en        (tick),
		.trigger       (cmd_valid),
		.timer_done    (timer_done),
		.timer_rdy     (timer_rdy),
		.servo_pos     (cmd_pos),
		.timer_trigger (timer_trigger),
		.servo_dir     (servo_dir),
		.done          (done),
		.rdy           (rdy)
	);

	servo_move_timer timer_i (
		.clk           (clk),
		.reset         (reset),
		.timer_trigger (timer_trigger),
		.tick          (tick),
		.timer_rdy     (timer_rdy),
		.timer_done    (timer_done)
	);

	servo_pwm pwm_i (
		.clk       (clk),
		.reset     (reset),
		.servo_dir (servo_dir),
		.pwm_out   (pwm_out)
	);

endmodule : servo_top

//--- test/servo_tb.sv
`timescale 1ns/1ps
`include "servo_consts.svh"

module servo_tb
	import servo_pkg::*;
();

	localparam int NUM_FIXED   = 10;
	localparam int NUM_ENTRIES = NUM_FIXED + 12;
	localparam int BURST_LEN   = `SERVO_FIFO_DEPTH + 2;
	localparam int WAIT_LIMIT  = 200;
	localparam int FRAME_LIMIT = 2 * `SERVO_PWM_PERIOD;
	localparam int unsigned RAND_SEED = 32'hc8fe_75d8;

	logic       clk = 1'b0;
	logic       reset;
	logic       cmd_strobe;
	servo_op_t  cmd_code;
	logic       pwm_out;
	servo_dir_t servo_dir;
	logic       done;
	logic       rdy;
	logic       overflow;
	logic       reject;

	// Stimulus table with expected reject and resting position.
	servo_op_t  tbl_code   [NUM_ENTRIES];
	logic       tbl_reject [NUM_ENTRIES];
	servo_pos_t tbl_pos    [NUM_ENTRIES];

	servo_pos_t  model_pos;
	logic        seen_move;

	servo_top dut_i (
		.clk        (clk),
		.reset      (reset),
		.cmd_strobe (cmd_strobe),
		.cmd_code   (cmd_code),
		.pwm_out    (pwm_out),
		.servo_dir  (servo_dir),
		.done       (done),
		.rdy        (rdy),
		.overflow   (overflow),
		.reject     (reject)
	);

	always #50 clk = ~clk;

	// **********************************************************************
	// Reference model.
	// **********************************************************************
	function automatic servo_pos_t next_position(input servo_op_t code, input servo_pos_t pos);
		case (code)
			OP_UP:   return SERVO_POS_UP;
			OP_DOWN: return SERVO_POS_DOWN;
			default: return pos;
		endcase
	endfunction

	function automatic int pulse_for(input servo_pos_t pos);
		return (pos == SERVO_POS_DOWN) ? `SERVO_PULSE_DOWN : `SERVO_PULSE_UP;
	endfunction

	function automatic servo_dir_t dir_toward(input servo_pos_t pos);
		return (pos == SERVO_POS_DOWN) ? SERVO_DIR_DOWN : SERVO_DIR_UP;
	endfunction

	// **********************************************************************
	// Checks and waits.
	// **********************************************************************
	task automatic report_failure(input string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1, "Simulation stopped at the first error.");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			report_failure($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
		end
	endtask

	// Any movement must point at the target while rdy is low.
	task automatic observe_dir(input servo_dir_t exp_dir);
		if (servo_dir != SERVO_DIR_STAY) begin
			seen_move = 1'b1;
			check_value("servo_dir", 32'(servo_dir), 32'(exp_dir));
			check_value("rdy", 32'(rdy), 32'd0);
		end
	endtask

	task automatic check_idle(input logic exp_ovf);
		check_value("rdy", 32'(rdy), 32'd1);
		check_value("done", 32'(done), 32'd1);
		check_value("servo_dir", 32'(servo_dir), 32'(SERVO_DIR_STAY));
		check_value("overflow", 32'(overflow), 32'(exp_ovf));
	endtask

	// One command passes the done state before the FSM is ready again.
	task automatic wait_command_end(input servo_dir_t exp_dir);
		int cycles;
		cycles = 0;
		while (!(done && !rdy)) begin
			if (cycles >= WAIT_LIMIT) begin
				report_failure("Timed out waiting for the FSM to reach its done state.");
			end else begin
				@(negedge clk);
				observe_dir(exp_dir);
				cycles++;
			end
		end
		cycles = 0;
		while (!rdy) begin
			if (cycles >= WAIT_LIMIT) begin
				report_failure("Timed out waiting for rdy after the done state.");
			end else begin
				@(negedge clk);
				observe_dir(exp_dir);
				cycles++;
			end
		end
	endtask

	task automatic wait_pwm_level(input logic level);
		int cycles;
		cycles = 0;
		while (pwm_out !== level) begin
			if (cycles >= FRAME_LIMIT) begin
				report_failure("Timed out waiting for the PWM output to change.");
			end else begin
				@(negedge clk);
				cycles++;
			end
		end
	endtask

	// Width in clocks of the next pulse that starts.
	task automatic measure_pulse(output int width);
		width = 0;
		wait_pwm_level(1'b0);
		wait_pwm_level(1'b1);
		while (pwm_out && width <= FRAME_LIMIT) begin
			width++;
			@(negedge clk);
		end
	endtask

	// **********************************************************************
	// Stimulus.
	// **********************************************************************
	task automatic set_entry(input int idx, input servo_op_t code, input logic rej,
			input servo_pos_t pos);
		tbl_code[idx]   = code;
		tbl_reject[idx] = rej;
		tbl_pos[idx]    = pos;
	endtask

	task automatic fill_table();
		servo_pos_t pos;
		logic [1:0] raw;
		set_entry(0, OP_DOWN, 1'b0, SERVO_POS_DOWN);
		set_entry(1, OP_DOWN, 1'b0, SERVO_POS_DOWN);
		set_entry(2, OP_NOP, 1'b0, SERVO_POS_DOWN);
		set_entry(3, OP_BAD, 1'b1, SERVO_POS_DOWN);
		set_entry(4, OP_UP, 1'b0, SERVO_POS_UP);
		set_entry(5, OP_UP, 1'b0, SERVO_POS_UP);
		set_entry(6, OP_BAD, 1'b1, SERVO_POS_UP);
		set_entry(7, OP_NOP, 1'b0, SERVO_POS_UP);
		set_entry(8, OP_DOWN, 1'b0, SERVO_POS_DOWN);
		set_entry(9, OP_UP, 1'b0, SERVO_POS_UP);
		pos = tbl_pos[NUM_FIXED - 1];
		for (int i = NUM_FIXED; i < NUM_ENTRIES; i++) begin
			raw = 2'($urandom % 4);
			pos = next_position(servo_op_t'(raw), pos);
			set_entry(i, servo_op_t'(raw), servo_op_t'(raw) == OP_BAD, pos);
		end
	endtask

	task automatic send_command(input servo_op_t code);
		@(posedge clk);
		#5;
		cmd_strobe = 1'b1;
		cmd_code   = code;
		@(posedge clk);
		#5;
		cmd_strobe = 1'b0;
		cmd_code   = OP_NOP;
	endtask

	task automatic apply_entry(input int idx);
		servo_op_t code;
		logic      is_move;
		logic      exp_move;
		int        width;
		code      = tbl_code[idx];
		is_move   = (code == OP_UP) || (code == OP_DOWN);
		exp_move  = is_move && (tbl_pos[idx] != model_pos);
		seen_move = 1'b0;
		send_command(code);
		// Reject follows the strobe by one clock.
		@(negedge clk);
		check_value("reject", 32'(reject), 32'(tbl_reject[idx]));
		if (is_move) begin
			wait_command_end(dir_toward(tbl_pos[idx]));
		end else begin
			// Decoder and queue stages.
			repeat (2) begin
				@(negedge clk);
				observe_dir(dir_toward(tbl_pos[idx]));
			end
		end
		check_value("moved", 32'(seen_move), 32'(exp_move));
		check_idle(1'b0);
		measure_pulse(width);
		check_value("pulse_width", 32'(width), 32'(pulse_for(tbl_pos[idx])));
		model_pos = tbl_pos[idx];
	endtask

	// Back-to-back alternating moves overrun the queue by one.
	task automatic run_burst();
		servo_op_t  far_code;
		servo_op_t  near_code;
		servo_pos_t target;
		int         width;
		far_code  = (model_pos == SERVO_POS_UP) ? OP_DOWN : OP_UP;
		near_code = (model_pos == SERVO_POS_UP) ? OP_UP : OP_DOWN;
		@(posedge clk);
		#5;
		cmd_strobe = 1'b1;
		for (int k = 0; k < BURST_LEN; k++) begin
			cmd_code = ((k % 2) == 0) ? far_code : near_code;
			@(posedge clk);
			#5;
		end
		cmd_strobe = 1'b0;
		cmd_code   = OP_NOP;
		// The last move of the burst is lost to overflow.
		for (int k = 0; k < BURST_LEN - 1; k++) begin
			target    = next_position(((k % 2) == 0) ? far_code : near_code, model_pos);
			seen_move = 1'b0;
			wait_command_end(dir_toward(target));
			check_value("moved", 32'(seen_move), 32'(target != model_pos));
			model_pos = target;
		end
		check_idle(1'b1);
		measure_pulse(width);
		check_value("pulse_width", 32'(width), 32'(pulse_for(model_pos)));
	endtask

	initial begin
		int width;
		void'($urandom(RAND_SEED));
		reset      = 1'b1;
		cmd_strobe = 1'b0;
		cmd_code   = OP_NOP;
		model_pos  = SERVO_POS_UP;
		seen_move  = 1'b0;
		fill_table();
		repeat (4) @(posedge clk);
		#5;
		reset = 1'b0;
		@(negedge clk);
		check_idle(1'b0);
		check_value("reject", 32'(reject), 32'd0);
		measure_pulse(width);
		check_value("pulse_width", 32'(width), 32'(`SERVO_PULSE_UP));
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			apply_entry(i);
		end
		run_burst();
		$display(">>> PASS");
		$finish;
	end

endmodule : servo_tb

//--- vlog.f
+incdir+include
hdl/servo_pkg.sv
hdl/servo_cmd_decoder.sv
hdl/servo_cmd_fifo.sv
hdl/servo_ctrl_fsm.sv
hdl/servo_move_timer.sv
hdl/servo_pwm.sv
hdl/servo_top.sv
test/servo_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the servo controller testbench with Verilator and runs it.
# The run passes only if the simulation output holds the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module servo_tb \
	-Mdir obj_dir -o servo_sim || { echo "Verilator build failed"; exit 1; }

sim_out="$(./obj_dir/servo_sim 2>&1)"
printf '%s\n' "$sim_out"

printf '%s\n' "$sim_out" | grep -qx -- '>>> PASS' \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
